//--- logic/attn_defines.svh
`ifndef ATTN_DEFINES_SVH
`define ATTN_DEFINES_SVH

// Lanes per key row. The adder tree is built for exactly 16.
`define ATTN_LANES 16

// Width of one signed Q8.8 element.
`define ATTN_DATA_W 16

// Fraction bits of the Q8.8 format.
`define ATTN_FRAC 8

// Number of key rows held in the key memory.
`define ATTN_ROWS 32

// Width of a row index, log2 of ATTN_ROWS.
`define ATTN_ROW_W 5

`endif

//--- logic/attn_pkg.sv
`include "attn_defines.svh"

package attn_pkg;

	// One signed Q8.8 element.
	typedef logic signed [`ATTN_DATA_W-1:0] fix_t;

	// Lane 0 sits in the low bits. Used for the query, a key row and a set of lane products.
	typedef fix_t [`ATTN_LANES-1:0] key_row_t;

	typedef logic [`ATTN_ROW_W-1:0] row_idx_t;

	typedef enum logic {
		SWEEP_IDLE,
		SWEEP_RUN
	} sweep_state_e;

endpackage

//--- logic/mem_port_if.sv
`timescale 1ns/1ns

interface mem_port_if;
	import attn_pkg::*;

	logic     en;
	logic     we;
	row_idx_t addr;
	key_row_t wdata;
	key_row_t rdata; // Row of the last read access.

	modport ctrl (
		output en,
		output we,
		output addr,
		output wdata,
		input  rdata
	);

	modport mem (
		input  en,
		input  we,
		input  addr,
		input  wdata,
		output rdata
	);

endinterface

//--- logic/lane_prod_if.sv
`timescale 1ns/1ns

interface lane_prod_if;
	import attn_pkg::*;

	logic     valid;
	row_idx_t row;
	logic     last; // Marks the final row of a sweep.
	key_row_t prod;

	modport src (
		output valid,
		output row,
		output last,
		output prod
	);

	modport dst (
		input valid,
		input row,
		input last,
		input prod
	);

endinterface

//--- logic/key_mem.sv
`timescale 1ns/1ns
`include "attn_defines.svh"

module key_mem (
	input logic     clk,
	mem_port_if.mem mem
);
	import attn_pkg::*;

	key_row_t rows [`ATTN_ROWS];

	// Single port. A write and a read never happen in the same cycle.
	always_ff @(posedge clk) begin
		if (mem.en) begin
			if (mem.we) begin
				rows[mem.addr] <= mem.wdata;
			end else begin
				mem.rdata <= rows[mem.addr]; // Read data shows up one cycle later.
			end
		end
	end

endmodule

//--- logic/key_mem_arbiter.sv
`timescale 1ns/1ns

module key_mem_arbiter (
	input  logic               clk,
	input  logic               reset,
	input  logic               k_wr,
	input  attn_pkg::row_idx_t k_addr,
	input  attn_pkg::key_row_t k_data,
	input  logic               rd_req,
	input  attn_pkg::row_idx_t rd_addr,
	output logic               rd_gnt,
	output attn_pkg::key_row_t rd_data,
	mem_port_if.ctrl           mem
);
	import attn_pkg::*;

	logic rd_gnt_q;

	// Host writes have no back-pressure, so they always take the port.
	assign rd_gnt = rd_req && !k_wr;

	assign mem.en    = k_wr || rd_req;
	assign mem.we    = k_wr;
	assign mem.addr  = k_wr ? k_addr : rd_addr;
	assign mem.wdata = k_data;

	// Remembers whether the memory output holds a fresh row this cycle.
	always_ff @(posedge clk) begin
		if (!reset) begin
			rd_gnt_q <= 1'b0;
		end else begin
			rd_gnt_q <= rd_gnt;
		end
	end

	// Idle cycles feed zeros so the multipliers do not toggle on stale rows.
	assign rd_data = rd_gnt_q ? mem.rdata : '0;

endmodule

//--- logic/score_sweeper.sv
`timescale 1ns/1ns
`include "attn_defines.svh"

module score_sweeper (
	input  logic               clk,
	input  logic               reset,
	input  logic               sweep_start,
	output logic               rd_req,
	output attn_pkg::row_idx_t rd_addr,
	input  logic               rd_gnt,
	output logic               sweep_busy,
	output logic               tag_valid,
	output attn_pkg::row_idx_t tag_row,
	output logic               tag_last
);
	import attn_pkg::*;

	sweep_state_e state;
	row_idx_t     row_cnt;
	logic         last_row;

	assign last_row   = (row_cnt == row_idx_t'(`ATTN_ROWS - 1));
	assign rd_req     = (state == SWEEP_RUN);
	assign rd_addr    = row_cnt;
	assign sweep_busy = (state == SWEEP_RUN);

	always_ff @(posedge clk) begin
		if (!reset) begin
			state   <= SWEEP_IDLE;
			row_cnt <= '0;
		end else begin
			case (state)
				SWEEP_IDLE: begin
					if (sweep_start) begin
						state   <= SWEEP_RUN;
						row_cnt <= '0;
					end
				end
				SWEEP_RUN: begin
					// A stalled cycle leaves the row where it is.
					if (rd_gnt) begin
						row_cnt <= row_cnt + 1'b1;
						if (last_row) begin
							state <= SWEEP_IDLE;
						end
					end
				end
				default: state <= SWEEP_IDLE;
			endcase
		end
	end

	// The tag trails the grant by one cycle, in step with the memory read data.
	always_ff @(posedge clk) begin
		if (!reset) begin
			tag_valid <= 1'b0;
			tag_last  <= 1'b0;
		end else begin
			tag_valid <= rd_gnt;
			tag_last  <= rd_gnt && last_row;
		end
	end

	always_ff @(posedge clk) begin
		tag_row <= rd_addr;
	end

endmodule

//--- logic/lane_multiplier.sv
`timescale 1ns/1ns
`include "attn_defines.svh"

module lane_multiplier (
	input  logic               clk,
	input  logic               reset,
	input  logic               q_wr,
	input  attn_pkg::key_row_t q_data,
	input  attn_pkg::key_row_t rd_data,
	input  logic               tag_valid,
	input  attn_pkg::row_idx_t tag_row,
	input  logic               tag_last,
	lane_prod_if.src           prod_out
);
	import attn_pkg::*;

	key_row_t query;
	key_row_t lane_prod;

	always_ff @(posedge clk) begin
		if (q_wr) begin
			query <= q_data;
		end
	end

	for (genvar i = 0; i < `ATTN_LANES; i++) begin : g_lane
		logic signed [2*`ATTN_DATA_W-1:0] full;
		logic signed [2*`ATTN_DATA_W-1:0] shifted;

		assign full    = $signed(query[i]) * $signed(rd_data[i]);
		assign shifted = full >>> `ATTN_FRAC; // Back to Q8.8 scale.

		// Upper bits are dropped, so large products wrap.
		assign lane_prod[i] = shifted[`ATTN_DATA_W-1:0];
	end

	always_ff @(posedge clk) begin
		prod_out.prod <= lane_prod;
		prod_out.row  <= tag_row;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			prod_out.valid <= 1'b0;
			prod_out.last  <= 1'b0;
		end else begin
			prod_out.valid <= tag_valid;
			prod_out.last  <= tag_last;
		end
	end

endmodule

//--- logic/adder_tree.sv
`timescale 1ns/1ns
`include "attn_defines.svh"

module adder_tree (
	input  logic               clk,
	input  logic               reset,
	lane_prod_if.dst           prod_in,
	output logic               score_valid,
	output attn_pkg::row_idx_t score_row,
	output attn_pkg::fix_t     score_data,
	output logic               sweep_done
);
	import attn_pkg::*;

	fix_t     lvl1 [`ATTN_LANES/2];
	fix_t     lvl2 [`ATTN_LANES/4];
	fix_t     mid_q [`ATTN_LANES/4];
	fix_t     lvl3 [`ATTN_LANES/8];
	fix_t     lvl4;
	logic     mid_valid;
	logic     mid_last;
	row_idx_t mid_row;

	// All sums are 16 bits wide and wrap on overflow.
	for (genvar i = 0; i < `ATTN_LANES/2; i++) begin : g_lvl1
		assign lvl1[i] = prod_in.prod[2*i] + prod_in.prod[2*i+1];
	end

	for (genvar i = 0; i < `ATTN_LANES/4; i++) begin : g_lvl2
		assign lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
	end

	// Mid-tree register splits the four levels into two stages.
	always_ff @(posedge clk) begin
		mid_q   <= lvl2;
		mid_row <= prod_in.row;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			mid_valid <= 1'b0;
			mid_last  <= 1'b0;
		end else begin
			mid_valid <= prod_in.valid;
			mid_last  <= prod_in.last;
		end
	end

	for (genvar i = 0; i < `ATTN_LANES/8; i++) begin : g_lvl3
		assign lvl3[i] = mid_q[2*i] + mid_q[2*i+1];
	end

	assign lvl4 = lvl3[0] + lvl3[1];

	always_ff @(posedge clk) begin
		score_data <= lvl4;
		score_row  <= mid_row;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			score_valid <= 1'b0;
			sweep_done  <= 1'b0;
		end else begin
			score_valid <= mid_valid;
			sweep_done  <= mid_valid && mid_last; // Pulses with the score of the final row.
		end
	end

endmodule

//--- logic/attn_score_unit.sv
`timescale 1ns/1ns

module attn_score_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               k_wr,
	input  attn_pkg::row_idx_t k_addr,
	input  attn_pkg::key_row_t k_data,
	input  logic               q_wr,
	input  attn_pkg::key_row_t q_data,
	input  logic               sweep_start,
	output logic               sweep_busy,
	output logic               score_valid,
	output attn_pkg::row_idx_t score_row,
	output attn_pkg::fix_t     score_data,
	output logic               sweep_done
);
	import attn_pkg::*;

	logic     rd_req;
	row_idx_t rd_addr;
	logic     rd_gnt;
	key_row_t rd_data;
	logic     tag_valid;
	row_idx_t tag_row;
	logic     tag_last;

	mem_port_if  mem_port ();
	lane_prod_if lane_prod ();

	key_mem i_key_mem (
		.clk (clk),
		.mem (mem_port.mem)
	);

	key_mem_arbiter i_arbiter (
		.clk     (clk),
		.reset   (reset),
		.k_wr    (k_wr),
		.k_addr  (k_addr),
		.k_data  (k_data),
		.rd_req  (rd_req),
		.rd_addr (rd_addr),
		.rd_gnt  (rd_gnt),
		.rd_data (rd_data),
		.mem     (mem_port.ctrl)
	);

	score_sweeper i_sweeper (
		.clk         (clk),
		.reset       (reset),
		.sweep_start (sweep_start),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.rd_gnt      (rd_gnt),
		.sweep_busy  (sweep_busy),
		.tag_valid   (tag_valid),
		.tag_row     (tag_row),
		.tag_last    (tag_last)
	);

	lane_multiplier i_multiplier (
		.clk       (clk),
		.reset     (reset),
		.q_wr      (q_wr),
		.q_data    (q_data),
		.rd_data   (rd_data),
		.tag_valid (tag_valid),
		.tag_row   (tag_row),
		.tag_last  (tag_last),
		.prod_out  (lane_prod.src)
	);

	adder_tree i_adder_tree (
		.clk         (clk),
		.reset       (reset),
		.prod_in     (lane_prod.dst),
		.score_valid (score_valid),
		.score_row   (score_row),
		.score_data  (score_data),
		.sweep_done  (sweep_done)
	);

endmodule

//--- dv/attn_tb.sv
`timescale 1ns/1ns
`include "attn_defines.svh"

module attn_tb;
	import attn_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int NUM_SWEEPS   = 6;
	localparam int STALL_MARGIN = 4;
	localparam int SWEEP_CYCLES = `ATTN_ROWS + 1 + `ATTN_ROWS * STALL_MARGIN + 16;
	localparam int TIMEOUT_NS   = (NUM_SWEEPS * SWEEP_CYCLES + 50) * CLK_PERIOD;

	typedef struct packed {
		logic [31:0] due;
		row_idx_t    row;
		fix_t        score;
	} score_exp_t;

	logic     clk;
	logic     reset;
	logic     k_wr;
	row_idx_t k_addr;
	key_row_t k_data;
	logic     q_wr;
	key_row_t q_data;
	logic     sweep_start;
	logic     sweep_busy;
	logic     score_valid;
	row_idx_t score_row;
	fix_t     score_data;
	logic     sweep_done;

	logic [31:0] lcg_state = 32'h1048;
	key_row_t    model_keys [`ATTN_ROWS];
	key_row_t    model_query;
	logic        model_busy = 1'b0;
	int          model_row = 0;
	int          cycle_cnt = 0;
	int          sweeps_done = 0;
	score_exp_t  exp_q [$];

	attn_score_unit i_dut (
		.clk         (clk),
		.reset       (reset),
		.k_wr        (k_wr),
		.k_addr      (k_addr),
		.k_data      (k_data),
		.q_wr        (q_wr),
		.q_data      (q_data),
		.sweep_start (sweep_start),
		.sweep_busy  (sweep_busy),
		.score_valid (score_valid),
		.score_row   (score_row),
		.score_data  (score_data),
		.sweep_done  (sweep_done)
	);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16; // Low LCG bits repeat too quickly.
	endfunction

	function automatic key_row_t random_row(bit extreme);
		key_row_t row;
		for (int i = 0; i < `ATTN_LANES; i++) begin
			row[i] = fix_t'(next_rand());
			if (extreme) begin
				case (next_rand() % 4)
					0: row[i] = 16'h8000;
					1: row[i] = 16'h7FFF;
					2: row[i] = 16'hFFFF;
					default: ;
				endcase
			end
		end
		return row;
	endfunction

	// Each product is shifted back by 8 bits and every sum wraps to 16 bits.
	function automatic fix_t expected_score(key_row_t q, key_row_t k);
		fix_t acc;
		int   prod;
		acc = '0;
		for (int i = 0; i < `ATTN_LANES; i++) begin
			prod = int'(q[i]) * int'(k[i]);
			prod = prod >>> `ATTN_FRAC;
			acc  = acc + prod[`ATTN_DATA_W-1:0];
		end
		return acc;
	endfunction

	task automatic stop_with_failure();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		k_wr        = 1'b0; // Strobes last a single cycle.
		q_wr        = 1'b0;
		sweep_start = 1'b0;
	endtask

	task automatic load_keys(bit extreme);
		for (int r = 0; r < `ATTN_ROWS; r++) begin
			k_wr   = 1'b1;
			k_addr = row_idx_t'(r);
			k_data = random_row(extreme);
			next_cycle();
		end
		q_wr   = 1'b1;
		q_data = random_row(extreme);
		next_cycle();
	endtask

	// Host writes steal random cycles and extra starts hit the busy sweeper.
	task automatic run_sweep(int stall_pct);
		int target;
		target      = sweeps_done + 1;
		sweep_start = 1'b1;
		next_cycle();
		while (sweeps_done < target) begin
			if ((next_rand() % 100) < stall_pct) begin
				k_wr   = 1'b1;
				k_addr = row_idx_t'(next_rand());
				k_data = random_row(1'b0);
			end
			if (model_busy && (next_rand() % 8) == 0) begin
				sweep_start = 1'b1;
			end
			next_cycle();
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// The model grants one row per cycle in which the host does not write.
	always @(posedge clk) begin
		score_exp_t item;
		cycle_cnt = cycle_cnt + 1;
		if (!reset) begin
			model_busy = 1'b0;
			model_row  = 0;
		end else begin
			if (model_busy) begin
				if (!k_wr) begin
					// This edge closes the grant cycle, so the score is three edges away.
					item.due   = cycle_cnt + 3;
					item.row   = row_idx_t'(model_row);
					item.score = expected_score(model_query, model_keys[model_row]);
					exp_q.push_back(item);
					if (model_row == `ATTN_ROWS - 1) begin
						model_busy = 1'b0;
					end
					model_row = model_row + 1;
				end
			end else if (sweep_start) begin
				model_busy = 1'b1;
				model_row  = 0;
			end
			if (k_wr) model_keys[k_addr] = k_data;
			if (q_wr) model_query = q_data;
		end
	end

	always @(negedge clk) begin
		score_exp_t item;
		if (reset) begin
			assert (sweep_busy == model_busy) else begin
				$display("MISMATCH at %0t: sweep_busy is %b, expected %b", $time,
					sweep_busy, model_busy);
				stop_with_failure();
			end
			if (exp_q.size() > 0 && exp_q[0].due == cycle_cnt) begin
				item = exp_q.pop_front();
				assert (score_valid && score_row == item.row && score_data == item.score) else begin
					$display("MISMATCH at %0t: got valid %b row %0d score %h, expected row %0d score %h",
						$time, score_valid, score_row, score_data, item.row, item.score);
					stop_with_failure();
				end
				assert (sweep_done == (item.row == row_idx_t'(`ATTN_ROWS - 1))) else begin
					$display("MISMATCH at %0t: sweep_done is %b at row %0d", $time,
						sweep_done, item.row);
					stop_with_failure();
				end
				if (sweep_done) begin
					sweeps_done = sweeps_done + 1;
				end
			end else begin
				assert (!score_valid && !sweep_done) else begin
					$display("MISMATCH at %0t: score_valid %b sweep_done %b with no score due",
						$time, score_valid, sweep_done);
					stop_with_failure();
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: only %0d of %0d sweeps finished.", sweeps_done, NUM_SWEEPS);
		stop_with_failure();
	end

	initial begin
		reset       = 1'b0;
		k_wr        = 1'b0;
		k_addr      = '0;
		k_data      = '0;
		q_wr        = 1'b0;
		q_data      = '0;
		sweep_start = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b1;
		repeat (10) next_cycle(); // Outputs must stay quiet before any start.
		load_keys(1'b0);
		run_sweep(0);
		repeat (3) begin
			load_keys(1'b0);
			run_sweep(30);
		end
		load_keys(1'b1);
		run_sweep(0);
		load_keys(1'b1);
		run_sweep(30);
		repeat (8) next_cycle();
		if (exp_q.size() == 0 && sweeps_done == NUM_SWEEPS) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("Run ended with %0d scores outstanding after %0d sweeps.",
				exp_q.size(), sweeps_done);
			stop_with_failure();
		end
	end

endmodule

//--- vlog.f
+incdir+logic
logic/attn_pkg.sv
logic/mem_port_if.sv
logic/lane_prod_if.sv
logic/key_mem.sv
logic/key_mem_arbiter.sv
logic/score_sweeper.sv
logic/lane_multiplier.sv
logic/adder_tree.sv
logic/attn_score_unit.sv
dv/attn_tb.sv

//--- Makefile
# Verilator build and run of the attention-score testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module attn_tb \
		--Mdir obj_dir -o attn_sim
	./obj_dir/attn_sim | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
